// File: hdl/sched_cfg_pkg.sv
// scheduler configuration package
// slot count, source and wakeup port counts, tag width and tag-level types
`default_nettype none

package sched_cfg_pkg;

  // scheduler geometry
  localparam int NUM_SLOTS    = 8;
  localparam int NUM_SRCS     = 2;
  // port 0 is the internal execute pipe, port 1 the external completion bus
  localparam int NUM_WAKE     = 2;
  localparam int TAG_WIDTH    = 5;
  // cycles from issue to the port 0 broadcast
  localparam int EXEC_LATENCY = 2;

  typedef logic [TAG_WIDTH-1:0] tag_t;

  // one bit per scheduler slot
  typedef logic [NUM_SLOTS-1:0] slot_oh_t;

  // bit [s][p] set when source s was cleared by wake port p
  typedef logic [NUM_SRCS-1:0][NUM_WAKE-1:0] wake_src_t;

endpackage

`default_nettype wire

// File: hdl/sched_dataflow.sv
// dataflow scheduler core
// slot array with payload storage, lowest-ready issue select and
// valid/yumi insert handshake
`timescale 1ns/10ps
`default_nettype none

module sched_dataflow
  import sched_cfg_pkg::*;
  import sched_op_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        insert_v_i,
  input  insert_req_t insert_req_i,
  output logic        insert_yumi_o,
  input  wake_bus_t   wake_i,
  output logic        issue_v_o,
  output issue_t      issue_o
);

  slot_oh_t active;
  slot_oh_t alloc_oh;
  logic     alloc_v;
  slot_oh_t slot_we;
  slot_oh_t slot_ready;
  slot_oh_t ready_to_issue;
  slot_oh_t issue_oh;

  op_payload_t payload_r     [NUM_SLOTS];
  wake_src_t   slot_wake_src [NUM_SLOTS];

  // accept whenever a slot is free, no registered stage in between
  assign insert_yumi_o = insert_v_i & alloc_v;
  assign slot_we       = insert_yumi_o ? alloc_oh : '0;

  sched_id_pool pool
  (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .active_o     (active),
    .alloc_oh_o   (alloc_oh),
    .alloc_v_o    (alloc_v),
    .alloc_yumi_i (insert_yumi_o),
    // the issuing slot goes back to the pool at this edge
    .dealloc_i    (issue_oh)
  );

  for (genvar i = 0; i < NUM_SLOTS; i++)
  begin : g_slot
    sched_entry entry
    (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .we_i       (slot_we[i]),
      .src_i      (insert_req_i.src),
      .wake_i     (wake_i),
      .ready_o    (slot_ready[i]),
      .wake_src_o (slot_wake_src[i])
    );

    // opcode, dest and seq held alongside the entry
    always_ff @(posedge clk_i)
    begin
      if (slot_we[i])
        payload_r[i] <= insert_req_i.payload;
    end
  end

  // free slots can look ready, so mask with the active vector
  assign ready_to_issue = slot_ready & active;

  // lowest ready slot wins
  assign issue_oh  = ready_to_issue & (~ready_to_issue + 1'b1);
  assign issue_v_o = |ready_to_issue;

  sched_onehot_mux #(.payload_t(op_payload_t)) payload_mux
  (
    .data_i (payload_r),
    .sel_i  (issue_oh),
    .data_o (issue_o.payload)
  );

  // wake-source record for the bypass mux downstream
  sched_onehot_mux #(.payload_t(wake_src_t)) wake_src_mux
  (
    .data_i (slot_wake_src),
    .sel_i  (issue_oh),
    .data_o (issue_o.wake_src)
  );

endmodule

`default_nettype wire

// File: hdl/sched_entry.sv
// scheduler slot
// tracks pending source tags, clears them on matching wakeups and
// remembers which wakeup port satisfied each source
`timescale 1ns/10ps
`default_nettype none

module sched_entry
  import sched_cfg_pkg::*;
  import sched_op_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      we_i,
  input  src_set_t  src_i,
  input  wake_bus_t wake_i,
  output logic      ready_o,
  output wake_src_t wake_src_o
);

  logic [NUM_SRCS-1:0] pend_r;
  tag_t [NUM_SRCS-1:0] tag_r;
  wake_src_t           wake_src_r;

  // sources under comparison this cycle, fresh ones on a write
  logic [NUM_SRCS-1:0] cmp_pend;
  tag_t [NUM_SRCS-1:0] cmp_tag;
  wake_src_t           match;

  always_comb
  begin
    cmp_pend = we_i ? src_i.v : pend_r;
    cmp_tag  = we_i ? src_i.tag : tag_r;
    for (int s = 0; s < NUM_SRCS; s++)
    begin
      for (int p = 0; p < NUM_WAKE; p++)
      begin
        // only a source still waiting can be matched
        match[s][p] = cmp_pend[s] & wake_i.v[p] & (cmp_tag[s] == wake_i.tag[p]);
      end
    end
  end

  // tags only matter while pending
  always_ff @(posedge clk_i)
  begin
    if (we_i)
      tag_r <= src_i.tag;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pend_r     <= '0;
      wake_src_r <= '0;
    end
    else
    begin
      for (int s = 0; s < NUM_SRCS; s++)
      begin
        pend_r[s] <= cmp_pend[s] & ~(|match[s]);
        // a write starts a new record, otherwise keep collecting
        if (we_i)
          wake_src_r[s] <= match[s];
        else
          wake_src_r[s] <= wake_src_r[s] | match[s];
      end
    end
  end

  assign ready_o    = ~(|pend_r);
  assign wake_src_o = wake_src_r;

  for (genvar s = 0; s < NUM_SRCS; s++)
  begin : g_chk
    // two ports may only clear the same source when they broadcast one tag
    a_dual_clear : assert property (@(posedge clk_i) disable iff (reset_i)
      !$onehot0(match[s]) |-> (wake_i.tag[0] == wake_i.tag[1]));
  end

endmodule

`default_nettype wire

// File: hdl/sched_id_pool.sv
// slot allocator
// holds the active-slot vector and offers the lowest free slot one-hot
`timescale 1ns/10ps
`default_nettype none

module sched_id_pool
  import sched_cfg_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  output slot_oh_t active_o,
  output slot_oh_t alloc_oh_o,
  output logic     alloc_v_o,
  input  logic     alloc_yumi_i,
  input  slot_oh_t dealloc_i
);

  slot_oh_t active_r;
  slot_oh_t free;
  slot_oh_t set_mask;

  assign free = ~active_r;

  // isolate the lowest set bit of the free vector
  assign alloc_oh_o = free & (~free + 1'b1);
  assign alloc_v_o  = |free;

  assign set_mask = alloc_yumi_i ? alloc_oh_o : '0;

  // freed slots are offered again only from the following cycle
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      active_r <= '0;
    else
      active_r <= (active_r & ~dealloc_i) | set_mask;
  end

  assign active_o = active_r;

  // issue logic must only free slots that hold an op
  a_dealloc_active : assert property (@(posedge clk_i) disable iff (reset_i)
    (dealloc_i & ~active_r) == '0);

  // the insert side may only accept when a slot was offered
  a_yumi_needs_v : assert property (@(posedge clk_i) disable iff (reset_i)
    alloc_yumi_i |-> alloc_v_o);

endmodule

`default_nettype wire

// File: hdl/sched_onehot_mux.sv
// one-hot selector over the scheduler slots
// ors together every entry whose select bit is set
`timescale 1ns/10ps
`default_nettype none

module sched_onehot_mux
  import sched_cfg_pkg::*;
#(
  parameter type payload_t = logic
)
(
  input  payload_t data_i [NUM_SLOTS],
  input  slot_oh_t sel_i,
  output payload_t data_o
);

  always_comb
  begin
    // empty select gives all zeros
    data_o = '0;
    for (int i = 0; i < NUM_SLOTS; i++)
    begin
      if (sel_i[i])
        data_o = payload_t'(data_o | data_i[i]);
    end
  end

  // the select comes from a priority pick upstream
  always_comb
  begin
    if (!$isunknown(sel_i))
      a_sel_onehot : assert final ($onehot0(sel_i));
  end

endmodule

`default_nettype wire

// File: hdl/sched_op_pkg.sv
// scheduler operation package
// packed records carried on the insert, wakeup and issue interfaces
`default_nettype none

package sched_op_pkg;

  import sched_cfg_pkg::*;

  localparam int OPCODE_WIDTH = 4;
  localparam int SEQ_WIDTH    = 8;

  // v set means the op still waits for that tag
  typedef struct packed {
    logic [NUM_SRCS-1:0] v;
    tag_t [NUM_SRCS-1:0] tag;
  } src_set_t;

  // what travels with the op to the execute pipe
  typedef struct packed {
    logic [OPCODE_WIDTH-1:0] opcode;
    logic                    dest_v;
    tag_t                    dest_tag;
    // producer-assigned sequence number
    logic [SEQ_WIDTH-1:0]    seq;
  } op_payload_t;

  typedef struct packed {
    src_set_t    src;
    op_payload_t payload;
  } insert_req_t;

  // one valid and one tag per wakeup port
  typedef struct packed {
    logic [NUM_WAKE-1:0] v;
    tag_t [NUM_WAKE-1:0] tag;
  } wake_bus_t;

  typedef struct packed {
    op_payload_t payload;
    wake_src_t   wake_src;
  } issue_t;

endpackage

`default_nettype wire

// File: hdl/sched_top.sv
// scheduler top level
// scheduler core plus execute pipe, with the external completion port merged in
`timescale 1ns/10ps
`default_nettype none

module sched_top
  import sched_cfg_pkg::*;
  import sched_op_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        insert_v_i,
  input  insert_req_t insert_req_i,
  output logic        insert_yumi_o,
  input  logic        ext_wake_v_i,
  input  tag_t        ext_wake_tag_i,
  output logic        issue_v_o,
  output issue_t      issue_o,
  output wake_bus_t   wake_o
);

  logic pipe_wake_v;
  tag_t pipe_wake_tag;

  // port 0 from the pipe, port 1 from outside
  assign wake_o.v   = {ext_wake_v_i, pipe_wake_v};
  assign wake_o.tag = {ext_wake_tag_i, pipe_wake_tag};

  sched_dataflow sched
  (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .insert_v_i    (insert_v_i),
    .insert_req_i  (insert_req_i),
    .insert_yumi_o (insert_yumi_o),
    .wake_i        (wake_o),
    .issue_v_o     (issue_v_o),
    .issue_o       (issue_o)
  );

  sched_wakeup_pipe #(.latency_p(EXEC_LATENCY)) exec_pipe
  (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .issue_v_i  (issue_v_o),
    .dest_v_i   (issue_o.payload.dest_v),
    .dest_tag_i (issue_o.payload.dest_tag),
    .wake_v_o   (pipe_wake_v),
    .wake_tag_o (pipe_wake_tag)
  );

endmodule

`default_nettype wire

// File: hdl/sched_wakeup_pipe.sv
// fixed-latency execute pipe
// returns the dest tag of each issued op as a wakeup latency_p cycles later
`timescale 1ns/10ps
`default_nettype none

module sched_wakeup_pipe
  import sched_cfg_pkg::*;
#(
  parameter int latency_p = EXEC_LATENCY
)
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic issue_v_i,
  input  logic dest_v_i,
  input  tag_t dest_tag_i,
  output logic wake_v_o,
  output tag_t wake_tag_o
);

  typedef struct packed {
    logic v;
    tag_t tag;
  } stage_t;

  stage_t stage_r [latency_p];

  // every stage shifts each cycle, so several ops can be in flight
  always_ff @(posedge clk_i)
  begin
    stage_r[0].tag <= dest_tag_i;
    // only ops that write a dest produce a wakeup
    stage_r[0].v   <= ~reset_i & issue_v_i & dest_v_i;
    for (int i = 1; i < latency_p; i++)
    begin
      stage_r[i].tag <= stage_r[i-1].tag;
      stage_r[i].v   <= ~reset_i & stage_r[i-1].v;
    end
  end

  assign wake_v_o   = stage_r[latency_p-1].v;
  assign wake_tag_o = stage_r[latency_p-1].tag;

endmodule

`default_nettype wire

// File: sim/sched_checker.sv
// scheduler checker
// watches the DUT ports and compares insert, issue and wakeup
// behavior with a reference built from the observed wakeup log
`timescale 1ns/10ps
`default_nettype none

module sched_checker
  import sched_cfg_pkg::*;
  import sched_op_pkg::*;
(
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        insert_v_i,
  input  insert_req_t insert_req_i,
  input  logic        insert_yumi_i,
  input  logic        ext_wake_v_i,
  input  tag_t        ext_wake_tag_i,
  input  logic        issue_v_i,
  input  issue_t      issue_i,
  input  wake_bus_t   wake_i
);

  int cyc;
  int rst_edges;
  int outstanding;
  int accepted_cnt;
  int issued_cnt;
  int mismatch_cnt;
  int fault_cnt;

  // every valid wakeup seen on wake_i, in cycle order
  int   log_cyc  [$];
  int   log_port [$];
  tag_t log_tag  [$];

  // accepted ops not yet issued, indexed by seq
  logic        ent_v     [256];
  src_set_t    ent_src   [256];
  op_payload_t ent_pay   [256];
  int          ent_start [256];

  // port 0 broadcasts owed by the execute pipe
  int   p0_cyc [$];
  tag_t p0_tag [$];

  task automatic wrong_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    $display("mismatch %s: expected %0h, actual %0h", name, exp, act);
    mismatch_cnt++;
  endtask

  task automatic protocol_fault(input string what);
    $display("error at cycle %0d: %s", cyc, what);
    fault_cnt++;
  endtask

  // reference model of one op: each pending source is cleared by the first
  // cycle at or after insert that broadcasts its tag, on every port carrying it
  function automatic logic sources_woken(input src_set_t src, input int start,
                                         input int now, output wake_src_t ws);
    logic found;
    int   w;
    ws = '0;
    sources_woken = 1'b1;
    for (int s = 0; s < NUM_SRCS; s++)
    begin
      found = 1'b0;
      w = -1;
      for (int i = start; i < log_cyc.size(); i++)
      begin
        if (src.v[s] && log_cyc[i] < now && log_tag[i] == src.tag[s] &&
            (!found || log_cyc[i] == w))
        begin
          found = 1'b1;
          w = log_cyc[i];
          ws[s][log_port[i]] = 1'b1;
        end
      end
      if (src.v[s] && !found)
        sources_woken = 1'b0;
    end
  endfunction

  initial
  begin
    cyc = 0;
    rst_edges = 0;
    outstanding = 0;
    accepted_cnt = 0;
    issued_cnt = 0;
    mismatch_cnt = 0;
    fault_cnt = 0;
    for (int i = 0; i < 256; i++)
      ent_v[i] = 1'b0;
  end

  always @(posedge clk_i)
  begin : monitor
    logic      exp_v;
    wake_src_t ws;
    wake_src_t ws_any;
    int        idx;
    if (reset_i)
    begin
      // registers hold reset values from the second reset edge on
      if (rst_edges > 0 && (insert_yumi_i !== 1'b0 || issue_v_i !== 1'b0 || wake_i.v !== '0))
        protocol_fault("yumi, issue valid or a wake valid is high during reset");
      rst_edges++;
    end
    else
    begin
      exp_v = insert_v_i && (outstanding < NUM_SLOTS);
      if (insert_yumi_i !== exp_v)
        wrong_value("insert_yumi", exp_v, insert_yumi_i);
      // something must issue whenever a held op has all sources woken
      exp_v = 1'b0;
      for (int i = 0; i < 256; i++)
      begin
        if (ent_v[i] && sources_woken(ent_src[i], ent_start[i], cyc, ws_any))
          exp_v = 1'b1;
      end
      if (issue_v_i !== exp_v)
        wrong_value("issue_v", exp_v, issue_v_i);
      if (issue_v_i === 1'b1)
      begin
        idx = issue_i.payload.seq;
        if (!ent_v[idx])
          protocol_fault($sformatf("seq %0d issued but not outstanding", idx));
        else
        begin
          if (!sources_woken(ent_src[idx], ent_start[idx], cyc, ws))
            protocol_fault($sformatf("seq %0d issued before its sources woke", idx));
          else if (issue_i.wake_src !== ws)
            wrong_value("wake_src", ws, issue_i.wake_src);
          if (issue_i.payload !== ent_pay[idx])
            wrong_value("issue_payload", ent_pay[idx], issue_i.payload);
          ent_v[idx] = 1'b0;
          issued_cnt++;
          if (issue_i.payload.dest_v)
          begin
            p0_cyc.push_back(cyc + EXEC_LATENCY);
            p0_tag.push_back(issue_i.payload.dest_tag);
          end
        end
      end
      if (p0_cyc.size() > 0 && p0_cyc[0] == cyc)
      begin
        if (wake_i.v[0] !== 1'b1)
          wrong_value("port0_wake_v", 1'b1, wake_i.v[0]);
        else if (wake_i.tag[0] !== p0_tag[0])
          wrong_value("port0_wake_tag", p0_tag[0], wake_i.tag[0]);
        p0_cyc.delete(0);
        p0_tag.delete(0);
      end
      else if (wake_i.v[0] !== 1'b0)
        protocol_fault("port 0 wakeup with no issued producer behind it");
      // port 1 carries the external completion bus unchanged
      if (wake_i.v[1] !== ext_wake_v_i)
        wrong_value("port1_wake_v", ext_wake_v_i, wake_i.v[1]);
      else if (ext_wake_v_i === 1'b1 && wake_i.tag[1] !== ext_wake_tag_i)
        wrong_value("port1_wake_tag", ext_wake_tag_i, wake_i.tag[1]);
      if (insert_yumi_i === 1'b1)
      begin
        idx = insert_req_i.payload.seq;
        if (ent_v[idx])
          protocol_fault($sformatf("seq %0d accepted while still outstanding", idx));
        ent_v[idx] = 1'b1;
        ent_src[idx] = insert_req_i.src;
        ent_pay[idx] = insert_req_i.payload;
        ent_start[idx] = log_cyc.size();
        accepted_cnt++;
      end
      outstanding = outstanding + (insert_yumi_i === 1'b1) - (issue_v_i === 1'b1);
      for (int p = 0; p < NUM_WAKE; p++)
      begin
        if (wake_i.v[p] === 1'b1)
        begin
          log_cyc.push_back(cyc);
          log_port.push_back(p);
          log_tag.push_back(wake_i.tag[p]);
        end
      end
    end
    cyc++;
  end

endmodule

`default_nettype wire

// File: sim/sched_tb.sv
// scheduler testbench
// random stream of dependent ops with internal and external producers
`timescale 1ns/10ps
`default_nettype none

module sched_tb
  import sched_cfg_pkg::*;
  import sched_op_pkg::*;
();

  localparam int NUM_OPS        = 300;
  localparam int HALF_PERIOD    = 2;
  localparam int RESET_CYCLES   = 10;
  localparam int TIMEOUT_CYCLES = NUM_OPS * 20;
  localparam int NUM_TAGS       = 2 ** TAG_WIDTH;

  // life of a tag used as a producer destination
  typedef enum logic [2:0]
  {
    TAG_FREE,
    TAG_WAIT_ISSUE,
    TAG_IN_PIPE,
    TAG_EXT_WAIT_ISSUE,
    TAG_EXT_RETURN
  } tag_state_e;

  logic        clk_i;
  logic        reset_i;
  logic        insert_v;
  insert_req_t insert_req;
  logic        insert_yumi;
  logic        ext_wake_v;
  tag_t        ext_wake_tag;
  logic        issue_v;
  issue_t      issue;
  wake_bus_t   wake;

  int          seed;
  tag_state_e  tag_state [NUM_TAGS];
  // ops whose tag returns on the external port
  logic        ext_op [256];
  int          built;
  int          issued_seen;
  int          lost_ops;
  logic        held_v;
  logic        held_ext;
  insert_req_t held_req;

  sched_top dut
  (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .insert_v_i     (insert_v),
    .insert_req_i   (insert_req),
    .insert_yumi_o  (insert_yumi),
    .ext_wake_v_i   (ext_wake_v),
    .ext_wake_tag_i (ext_wake_tag),
    .issue_v_o      (issue_v),
    .issue_o        (issue),
    .wake_o         (wake)
  );

  sched_checker chk
  (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .insert_v_i     (insert_v),
    .insert_req_i   (insert_req),
    .insert_yumi_i  (insert_yumi),
    .ext_wake_v_i   (ext_wake_v),
    .ext_wake_tag_i (ext_wake_tag),
    .issue_v_i      (issue_v),
    .issue_i        (issue),
    .wake_i         (wake)
  );

  always #HALF_PERIOD clk_i = ~clk_i;

  // random tag in either state, -1 when none exists
  function automatic int pick_tag(input tag_state_e st_a, input tag_state_e st_b);
    int cand [$];
    for (int t = 0; t < NUM_TAGS; t++)
    begin
      if (tag_state[t] == st_a || tag_state[t] == st_b)
        cand.push_back(t);
    end
    if (cand.size() == 0)
      return -1;
    return cand[{$random(seed)} % cand.size()];
  endfunction

  // track tag lifetimes from the cycle that just ended
  task automatic observe_cycle();
    if (insert_v && insert_yumi)
    begin
      if (held_ext)
        tag_state[held_req.payload.dest_tag] = TAG_EXT_WAIT_ISSUE;
      else if (held_req.payload.dest_v)
        tag_state[held_req.payload.dest_tag] = TAG_WAIT_ISSUE;
      ext_op[held_req.payload.seq] = held_ext;
      held_v = 1'b0;
    end
    if (issue_v === 1'b1)
    begin
      issued_seen++;
      if (issue.payload.dest_v)
        tag_state[issue.payload.dest_tag] = TAG_IN_PIPE;
      else if (ext_op[issue.payload.seq])
        tag_state[issue.payload.dest_tag] = TAG_EXT_RETURN;
    end
    if (wake.v[0] === 1'b1)
      tag_state[wake.tag[0]] = TAG_FREE;
  endtask

  // sources only wait on producers that have not issued yet
  task automatic build_request();
    int r;
    int t;
    held_req = '0;
    for (int s = 0; s < NUM_SRCS; s++)
    begin
      t = pick_tag(TAG_WAIT_ISSUE, TAG_EXT_WAIT_ISSUE);
      r = {$random(seed)} % 3;
      held_req.src.tag[s] = tag_t'($random(seed));
      if (t >= 0 && r != 0)
      begin
        held_req.src.v[s] = 1'b1;
        held_req.src.tag[s] = tag_t'(t);
      end
    end
    r = {$random(seed)} % 8;
    t = pick_tag(TAG_FREE, TAG_FREE);
    held_ext = (r == 2) && (t >= 0);
    held_req.payload.dest_v = (r > 2) && (t >= 0);
    held_req.payload.dest_tag = (t >= 0) ? tag_t'(t) : '0;
    held_req.payload.opcode = 4'($random(seed));
    held_req.payload.seq = 8'(built);
    built++;
    held_v = 1'b1;
  endtask

  // an external return must not race a held request that waits on it
  task automatic drive_ext_wake();
    int   t;
    logic clash;
    t = pick_tag(TAG_EXT_RETURN, TAG_EXT_RETURN);
    clash = 1'b0;
    for (int s = 0; s < NUM_SRCS; s++)
    begin
      if (held_v && held_req.src.v[s] && held_req.src.tag[s] == tag_t'(t))
        clash = 1'b1;
    end
    if (t >= 0 && !clash && ({$random(seed)} % 3) == 0)
    begin
      ext_wake_v <= 1'b1;
      ext_wake_tag <= tag_t'(t);
      tag_state[t] = TAG_FREE;
    end
    else
      ext_wake_v <= 1'b0;
  endtask

  initial
  begin
    seed = 16615;
    clk_i = 1'b0;
    reset_i = 1'b1;
    insert_v = 1'b0;
    insert_req = '0;
    ext_wake_v = 1'b0;
    ext_wake_tag = '0;
    built = 0;
    issued_seen = 0;
    lost_ops = 0;
    held_v = 1'b0;
    held_ext = 1'b0;
    held_req = '0;
    for (int t = 0; t < NUM_TAGS; t++)
      tag_state[t] = TAG_FREE;
    for (int i = 0; i < 256; i++)
      ext_op[i] = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    while (!(built == NUM_OPS && !held_v && issued_seen == NUM_OPS))
    begin
      @(posedge clk_i);
      observe_cycle();
      // idle cycles now and then between requests
      if (!held_v && built < NUM_OPS && ({$random(seed)} % 8) != 0)
        build_request();
      insert_v <= held_v;
      insert_req <= held_req;
      drive_ext_wake();
    end
    insert_v <= 1'b0;
    ext_wake_v <= 1'b0;
    // let the last broadcasts leave the execute pipe
    repeat (EXEC_LATENCY + 2) @(posedge clk_i);
    if (chk.accepted_cnt != NUM_OPS || chk.issued_cnt != NUM_OPS)
    begin
      $display("error: %0d ops accepted and %0d issued, %0d expected of each",
               chk.accepted_cnt, chk.issued_cnt, NUM_OPS);
      lost_ops = 1;
    end
    $display("errors: %0d mismatches, %0d other failures",
             chk.mismatch_cnt, chk.fault_cnt + lost_ops);
    if (chk.mismatch_cnt + chk.fault_cnt + lost_ops == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

  // budget of twenty cycles per op
  initial
  begin
    #(TIMEOUT_CYCLES * 2 * HALF_PERIOD);
    $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
hdl/sched_cfg_pkg.sv
hdl/sched_op_pkg.sv
hdl/sched_entry.sv
hdl/sched_id_pool.sv
hdl/sched_onehot_mux.sv
hdl/sched_dataflow.sv
hdl/sched_wakeup_pipe.sv
hdl/sched_top.sv
sim/sched_checker.sv
sim/sched_tb.sv
